// File: adam_cfg_pkg.sv
package adam_cfg_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // lpmem storage, 1 KiB of words
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    typedef logic [MEM_AW-1:0] mem_addr_t;

    // address map
    // only the first 1 KiB of the lpmem window is backed, the index wraps
    localparam addr_t LPMEM_BASE  = 32'h0000_0000;
    localparam addr_t LPMEM_MASK  = 32'h0000_0FFF;

    localparam addr_t SYSCFG_BASE = 32'h0001_0000;
    localparam addr_t SYSCFG_MASK = 32'h0000_00FF;

    // syscfg register offsets
    localparam addr_t SYSCFG_CTRL   = 32'h0;
    localparam addr_t SYSCFG_STATUS = 32'h4;
    localparam addr_t SYSCFG_BOOT   = 32'h8;

endpackage

// File: adam_bus_pkg.sv
package adam_bus_pkg;

    import adam_cfg_pkg::*;

    // request channel payload
    typedef struct packed {
        addr_t addr;
        logic  we;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    // response channel payload
    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    // single-cycle memory strobe
    typedef struct packed {
        mem_addr_t addr;
        logic      we;
        strb_t     be;
        data_t     wdata;
    } mem_cmd_t;

endpackage

// File: adam_mem.sv
`timescale 1ns/1ps

module adam_mem
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
(
    input  logic     clk,

    input  logic     req,
    input  mem_cmd_t cmd,
    output data_t    rdata
);

    data_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (req) begin
            if (cmd.we) begin
                // only enabled bytes change
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (cmd.be[i]) begin
                        mem[cmd.addr][8*i +: 8] <= cmd.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[cmd.addr];
            end
        end
    end

endmodule

// File: adam_axil_to_mem.sv
`timescale 1ns/1ps

module adam_axil_to_mem
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     unit_rst,

    input  logic     pause_req,
    output logic     pause_ack,

    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,

    output logic     mem_req,
    output mem_cmd_t mem_cmd,
    input  data_t    mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_PAUSED
    } state_e;

    state_e   state;
    bus_req_t req_q;

    // no new request once a pause is asked for
    assign req_ready = (state == ST_IDLE) && !pause_req && !unit_rst;
    assign pause_ack = (state == ST_PAUSED);

    // strobe built from the latched request, word index wraps
    assign mem_req       = (state == ST_ACCESS);
    assign mem_cmd.addr  = req_q.addr[MEM_AW+1:2];
    assign mem_cmd.we    = req_q.we;
    assign mem_cmd.be    = req_q.strb;
    assign mem_cmd.wdata = req_q.wdata;

    // memory output register holds the word until the next read strobe
    always_comb begin
        rsp.rdata = req_q.we ? '0 : mem_rdata;
        rsp.err   = 1'b0;
    end

    assign rsp_valid = (state == ST_RESPOND);

    always_ff @(posedge clk) begin
        if (rst || unit_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pause_req) begin
                        state <= ST_PAUSED;
                    end else if (req_valid) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state <= ST_RESPOND;
                end
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_PAUSED: begin
                    if (!pause_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

endmodule

// File: adam_syscfg.sv
`timescale 1ns/1ps

module adam_syscfg
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,

    output logic     lpmem_rst,
    output logic     lpmem_pause_req,
    input  logic     lpmem_pause_ack,

    output addr_t    boot_addr
);

    addr_t offset;
    logic  accept;
    data_t rd_data;
    logic  rd_err;

    assign offset    = req.addr & SYSCFG_MASK;
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;

    // register read mux
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (offset)
            SYSCFG_CTRL: begin
                rd_data = data_t'({lpmem_pause_req, lpmem_rst});
            end
            SYSCFG_STATUS: begin
                rd_data = data_t'(lpmem_pause_ack);
            end
            SYSCFG_BOOT: begin
                rd_data = data_t'(boot_addr);
            end
            default: begin
                rd_err = 1'b1;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            lpmem_rst       <= 1'b0;
            lpmem_pause_req <= 1'b0;
            boot_addr       <= '0;
        end else if (accept && req.we) begin
            case (offset)
                SYSCFG_CTRL: begin
                    // both bits live in byte 0
                    if (req.strb[0]) begin
                        lpmem_rst       <= req.wdata[0];
                        lpmem_pause_req <= req.wdata[1];
                    end
                end
                SYSCFG_BOOT: begin
                    for (int i = 0; i < STRB_WIDTH; i++) begin
                        if (req.strb[i]) begin
                            boot_addr[8*i +: 8] <= req.wdata[8*i +: 8];
                        end
                    end
                end
                default: begin
                    // status is read-only, others are unknown
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // response payload, held until taken
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.rdata <= req.we ? '0 : rd_data;
            rsp.err   <= rd_err;
        end
    end

endmodule

// File: adam_fabric.sv
`timescale 1ns/1ps

module adam_fabric
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,

    output bus_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,

    input  bus_rsp_t mem_rsp,
    input  logic     mem_rsp_valid,
    output logic     mem_rsp_ready,

    output bus_req_t cfg_req,
    output logic     cfg_req_valid,
    input  logic     cfg_req_ready,

    input  bus_rsp_t cfg_rsp,
    input  logic     cfg_rsp_valid,
    output logic     cfg_rsp_ready
);

    typedef enum logic [1:0] {
        TGT_IDLE,
        TGT_MEM,
        TGT_CFG,
        TGT_ERR
    } target_e;

    // slave that owes the response
    target_e tgt;

    logic hit_mem;
    logic hit_cfg;

    assign hit_mem = (req.addr & ~LPMEM_MASK) == LPMEM_BASE;
    assign hit_cfg = (req.addr & ~SYSCFG_MASK) == SYSCFG_BASE;

    // payload goes to both slaves, only valid is steered
    assign mem_req       = req;
    assign cfg_req       = req;
    assign mem_req_valid = req_valid && (tgt == TGT_IDLE) && hit_mem;
    assign cfg_req_valid = req_valid && (tgt == TGT_IDLE) && hit_cfg;

    always_comb begin
        if (tgt != TGT_IDLE) begin
            req_ready = 1'b0;
        end else if (hit_mem) begin
            req_ready = mem_req_ready;
        end else if (hit_cfg) begin
            req_ready = cfg_req_ready;
        end else begin
            // unmapped, taken at once
            req_ready = 1'b1;
        end
    end

    // response return path
    always_comb begin
        rsp           = '0;
        rsp_valid     = 1'b0;
        mem_rsp_ready = 1'b0;
        cfg_rsp_ready = 1'b0;
        case (tgt)
            TGT_MEM: begin
                rsp           = mem_rsp;
                rsp_valid     = mem_rsp_valid;
                mem_rsp_ready = rsp_ready;
            end
            TGT_CFG: begin
                rsp           = cfg_rsp;
                rsp_valid     = cfg_rsp_valid;
                cfg_rsp_ready = rsp_ready;
            end
            TGT_ERR: begin
                rsp.err   = 1'b1;
                rsp_valid = 1'b1;
            end
            default: begin
                rsp_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tgt <= TGT_IDLE;
        end else if (tgt == TGT_IDLE) begin
            if (req_valid && req_ready) begin
                if (hit_mem) begin
                    tgt <= TGT_MEM;
                end else if (hit_cfg) begin
                    tgt <= TGT_CFG;
                end else begin
                    tgt <= TGT_ERR;
                end
            end
        end else if (rsp_valid && rsp_ready) begin
            tgt <= TGT_IDLE;
        end
    end

endmodule

// File: adam_lsdom.sv
`timescale 1ns/1ps

module adam_lsdom
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,

    output addr_t    boot_addr
);

    // fabric to lpmem bridge
    bus_req_t lpmem_req;
    logic     lpmem_req_valid;
    logic     lpmem_req_ready;
    bus_rsp_t lpmem_rsp;
    logic     lpmem_rsp_valid;
    logic     lpmem_rsp_ready;

    // fabric to syscfg
    bus_req_t syscfg_req;
    logic     syscfg_req_valid;
    logic     syscfg_req_ready;
    bus_rsp_t syscfg_rsp;
    logic     syscfg_rsp_valid;
    logic     syscfg_rsp_ready;

    // lpmem control from syscfg
    logic lpmem_rst;
    logic lpmem_pause_req;
    logic lpmem_pause_ack;

    // bridge to storage
    logic     mem_strobe;
    mem_cmd_t mem_cmd;
    data_t    mem_rdata;

    adam_fabric u_fabric (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .mem_req       (lpmem_req),
        .mem_req_valid (lpmem_req_valid),
        .mem_req_ready (lpmem_req_ready),
        .mem_rsp       (lpmem_rsp),
        .mem_rsp_valid (lpmem_rsp_valid),
        .mem_rsp_ready (lpmem_rsp_ready),
        .cfg_req       (syscfg_req),
        .cfg_req_valid (syscfg_req_valid),
        .cfg_req_ready (syscfg_req_ready),
        .cfg_rsp       (syscfg_rsp),
        .cfg_rsp_valid (syscfg_rsp_valid),
        .cfg_rsp_ready (syscfg_rsp_ready)
    );

    adam_syscfg u_syscfg (
        .clk             (clk),
        .rst             (rst),
        .req             (syscfg_req),
        .req_valid       (syscfg_req_valid),
        .req_ready       (syscfg_req_ready),
        .rsp             (syscfg_rsp),
        .rsp_valid       (syscfg_rsp_valid),
        .rsp_ready       (syscfg_rsp_ready),
        .lpmem_rst       (lpmem_rst),
        .lpmem_pause_req (lpmem_pause_req),
        .lpmem_pause_ack (lpmem_pause_ack),
        .boot_addr       (boot_addr)
    );

    adam_axil_to_mem u_axil_to_mem (
        .clk       (clk),
        .rst       (rst),
        .unit_rst  (lpmem_rst),
        .pause_req (lpmem_pause_req),
        .pause_ack (lpmem_pause_ack),
        .req       (lpmem_req),
        .req_valid (lpmem_req_valid),
        .req_ready (lpmem_req_ready),
        .rsp       (lpmem_rsp),
        .rsp_valid (lpmem_rsp_valid),
        .rsp_ready (lpmem_rsp_ready),
        .mem_req   (mem_strobe),
        .mem_cmd   (mem_cmd),
        .mem_rdata (mem_rdata)
    );

    adam_mem u_mem (
        .clk   (clk),
        .req   (mem_strobe),
        .cmd   (mem_cmd),
        .rdata (mem_rdata)
    );

endmodule

// File: tb_adam_lsdom.sv
`timescale 1ns/1ps

module tb_adam_lsdom
    import adam_cfg_pkg::*;
    import adam_bus_pkg::*;
;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t exp_rdata;
        logic  exp_err;
    } case_t;

    logic     clk;
    logic     rst;
    bus_req_t req;
    logic     req_valid;
    logic     req_ready;
    bus_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    addr_t    boot_addr;

    case_t  cases[$];
    int     errors;
    int     cycles;
    int     timeout_cycles;
    integer seed;

    adam_lsdom u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .boot_addr (boot_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure on the response channel
    initial begin
        seed      = 32'h719b750f;
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        cycles = 0;
        wait (timeout_cycles != 0);
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic load_cases(output bit opened);
        int          fd;
        int          n;
        string       line;
        string       op_name;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [3:0]  sb;
        logic        e;
        case_t       c;
        opened = 1'b0;
        fd = $fopen("adam_lsdom_cases.txt", "r");
        if (fd != 0) begin
            opened = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h", op_name, a, wd, sb, rd, e);
                    if (n == 6 && (op_name == "write" || op_name == "read")) begin
                        c.is_write  = (op_name == "write");
                        c.addr      = a;
                        c.wdata     = wd;
                        c.strb      = sb;
                        c.exp_rdata = rd;
                        c.exp_err   = e;
                        cases.push_back(c);
                    end else begin
                        errors++;
                        $display("malformed line in the case file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input case_t c, input int idx);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        req.addr  = c.addr;
        req.we    = c.is_write;
        req.wdata = c.wdata;
        req.strb  = c.strb;
        req_valid = 1'b1;
        // hold the request until the fabric takes it
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        while (!(rsp_valid && rsp_ready)) @(negedge clk);
        check("rdata", rsp.rdata, c.exp_rdata);
        check("err", 32'(rsp.err), 32'(c.exp_err));
        if (!c.is_write && c.addr == (SYSCFG_BASE | SYSCFG_BOOT)) begin
            check("boot_addr", boot_addr, c.exp_rdata);
        end
        $display("case %0d %s %h: %s", idx, c.is_write ? "write" : "read ", c.addr,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        bit opened;
        rst            = 1'b1;
        req            = '0;
        req_valid      = 1'b0;
        errors         = 0;
        timeout_cycles = 0;
        load_cases(opened);
        if (!opened) begin
            $display("could not open adam_lsdom_cases.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            timeout_cycles = cases.size() * 20 + 100;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            foreach (cases[i]) begin
                run_case(cases[i], i);
            end
            $display("%0d cases run, %0d checks failed", cases.size(), errors);
            if (errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: adam_lsdom.f
adam_cfg_pkg.sv
adam_bus_pkg.sv
adam_mem.sv
adam_axil_to_mem.sv
adam_syscfg.sv
adam_fabric.sv
adam_lsdom.sv
tb_adam_lsdom.sv

// File: Makefile
TOP = tb_adam_lsdom

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f adam_lsdom.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f adam_lsdom.f --top-module adam_lsdom

clean:
	rm -rf obj_dir

// File: adam_lsdom_cases.txt
# op addr wdata strb exp_rdata exp_err, all values in hex
# op is write or read, writes expect rdata 0
write 00000000 deadbeef f 00000000 0
write 00000004 12345678 f 00000000 0
write 000003fc a5a5a5a5 f 00000000 0
write 00000410 cafef00d f 00000000 0
read 00000000 00000000 0 deadbeef 0
read 00000004 00000000 0 12345678 0
read 00000010 00000000 0 cafef00d 0
read 00000ffc 00000000 0 a5a5a5a5 0
write 00000020 11223344 f 00000000 0
write 00000020 000000aa 1 00000000 0
write 00000020 bb000000 8 00000000 0
write 00000020 00cc0000 4 00000000 0
read 00000020 00000000 0 bbcc33aa 0
write 00010008 80000000 f 00000000 0
read 00010008 00000000 0 80000000 0
write 00010008 00001234 3 00000000 0
read 00010008 00000000 0 80001234 0
write 00010004 ffffffff f 00000000 0
read 00010004 00000000 0 00000000 0
write 00020000 01020304 f 00000000 1
read 00020000 00000000 0 00000000 1
read 0001000c 00000000 0 00000000 1
write 00010000 00000002 1 00000000 0
read 00010004 00000000 0 00000001 0
read 00010000 00000000 0 00000002 0
write 00010000 00000000 1 00000000 0
read 00010004 00000000 0 00000000 0
read 00000004 00000000 0 12345678 0
write 00010000 00000001 1 00000000 0
read 00010000 00000000 0 00000001 0
write 00010000 00000000 1 00000000 0
read 00000000 00000000 0 deadbeef 0
read 00000020 00000000 0 bbcc33aa 0
